//--- soc_bus_pkg.sv
package soc_bus_pkg;

  // bus widths
  localparam int DATA_W = 32;
  localparam int ADDR_W = 32;
  localparam int SEL_W  = DATA_W / 8;

  // region select field, addr[31:28]
  localparam int REGION_LSB = 28;

  localparam logic [ADDR_W-1:0] RAM_BASE = 32'h1000_0000;
  localparam logic [ADDR_W-1:0] LED_BASE = 32'h8000_0000;
  localparam logic [ADDR_W-1:0] KEY_BASE = 32'hC000_0000;

  // on-chip data RAM
  localparam int RAM_WORDS = 1024;
  localparam int RAM_AW    = $clog2(RAM_WORDS);

  // board io
  localparam int LED_W = 8;
  localparam int KEY_W = 2;

  // key block register offsets, matched on addr[3:0]
  localparam logic [3:0] KEY_LEVEL_OFS = 4'h0;
  localparam logic [3:0] KEY_EVENT_OFS = 4'h4;

  // master to slave, held stable until ack
  typedef struct packed {
    logic              stb;   // request valid
    logic              we;    // write
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [SEL_W-1:0]  sel;   // byte selects
  } bus_req_t;

  // slave to master, fields valid only with ack
  typedef struct packed {
    logic              ack;   // one cycle
    logic              err;   // unmapped access
    logic [DATA_W-1:0] rdata;
  } bus_rsp_t;

endpackage

//--- bus_decoder.sv
module bus_decoder
  import soc_bus_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n_i,
  input  bus_req_t bus_req_i,
  output bus_rsp_t bus_rsp_o,
  output bus_req_t ram_req_o,
  input  bus_rsp_t ram_rsp_i,
  output bus_req_t led_req_o,
  input  bus_rsp_t led_rsp_i,
  output bus_req_t key_req_o,
  input  bus_rsp_t key_rsp_i
);

  logic [ADDR_W-REGION_LSB-1:0] region;
  logic                         hit_ram;
  logic                         hit_led;
  logic                         hit_key;
  logic                         miss;
  logic                         miss_ack_q;

  assign region  = bus_req_i.addr[ADDR_W-1:REGION_LSB];
  assign hit_ram = (region == RAM_BASE[ADDR_W-1:REGION_LSB]);
  assign hit_led = (region == LED_BASE[ADDR_W-1:REGION_LSB]);
  assign hit_key = (region == KEY_BASE[ADDR_W-1:REGION_LSB]);
  assign miss    = ~(hit_ram | hit_led | hit_key);

  // same payload to all slaves, only the hit one sees stb
  always_comb
  begin
    ram_req_o     = bus_req_i;
    led_req_o     = bus_req_i;
    key_req_o     = bus_req_i;
    ram_req_o.stb = bus_req_i.stb & hit_ram;
    led_req_o.stb = bus_req_i.stb & hit_led;
    key_req_o.stb = bus_req_i.stb & hit_key;
  end

  // unmapped access answered here, writes dropped
  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      miss_ack_q <= 1'b0;
    else
      miss_ack_q <= bus_req_i.stb & miss & ~miss_ack_q;
  end

  // slave data is only meaningful with its ack, so mask before the OR
  always_comb
  begin
    bus_rsp_o.ack   = ram_rsp_i.ack | led_rsp_i.ack | key_rsp_i.ack | miss_ack_q;
    bus_rsp_o.err   = miss_ack_q | (ram_rsp_i.ack & ram_rsp_i.err)
                    | (led_rsp_i.ack & led_rsp_i.err) | (key_rsp_i.ack & key_rsp_i.err);
    bus_rsp_o.rdata = ({DATA_W{ram_rsp_i.ack}} & ram_rsp_i.rdata)
                    | ({DATA_W{led_rsp_i.ack}} & led_rsp_i.rdata)
                    | ({DATA_W{key_rsp_i.ack}} & key_rsp_i.rdata);
  end

  a_one_slave: assert property (@(posedge clk) disable iff (!rst_n_i)
    $onehot0({ram_req_o.stb, led_req_o.stb, key_req_o.stb}));

  // holds across every slave, the master never sees a stretched ack
  a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
    bus_rsp_o.ack |=> !bus_rsp_o.ack);

endmodule

//--- ram_slave.sv
module ram_slave
  import soc_bus_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n_i,
  input  bus_req_t bus_req_i,
  output bus_rsp_t bus_rsp_o
);

  logic [DATA_W-1:0] mem [RAM_WORDS];
  logic [RAM_AW-1:0] idx;
  logic              take;
  logic              ack_q;
  logic [DATA_W-1:0] rdata_q;

  assign idx  = bus_req_i.addr[RAM_AW+1:2]; // word index, region checked upstream
  assign take = bus_req_i.stb & ~ack_q;

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      ack_q <= 1'b0;
    else
      ack_q <= take;
  end

  // byte lane writes, whole word read
  always_ff @(posedge clk)
  begin
    if (take && bus_req_i.we)
    begin
      for (int b = 0; b < SEL_W; b++)
      begin
        if (bus_req_i.sel[b])
          mem[idx][8*b +: 8] <= bus_req_i.wdata[8*b +: 8];
      end
    end
    rdata_q <= mem[idx];
  end

  always_comb
  begin
    bus_rsp_o.ack   = ack_q;
    bus_rsp_o.err   = 1'b0;
    bus_rsp_o.rdata = rdata_q;
  end

  a_ack_follows_stb: assert property (@(posedge clk) disable iff (!rst_n_i)
    bus_rsp_o.ack |-> $past(bus_req_i.stb));

endmodule

//--- led_slave.sv
module led_slave
  import soc_bus_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n_i,
  input  bus_req_t         bus_req_i,
  output bus_rsp_t         bus_rsp_o,
  output logic [LED_W-1:0] led_o
);

  logic             take;
  logic             ack_q;
  logic [LED_W-1:0] led_q;

  assign take = bus_req_i.stb & ~ack_q;

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      ack_q <= 1'b0;
      led_q <= '0;
    end
    else
    begin
      ack_q <= take;
      if (take && bus_req_i.we && bus_req_i.sel[0]) // low byte lane only
        led_q <= bus_req_i.wdata[LED_W-1:0];
    end
  end

  assign led_o = led_q;

  always_comb
  begin
    bus_rsp_o.ack   = ack_q;
    bus_rsp_o.err   = 1'b0;
    bus_rsp_o.rdata = {{(DATA_W-LED_W){1'b0}}, led_q};
  end

endmodule

//--- key_slave.sv
module key_slave
  import soc_bus_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n_i,
  input  logic [KEY_W-1:0] key_i,     // active low
  input  bus_req_t         bus_req_i,
  output bus_rsp_t         bus_rsp_o
);

  logic [KEY_W-1:0]  key_meta;
  logic [KEY_W-1:0]  key_sync;
  logic [KEY_W-1:0]  pressed;
  logic [KEY_W-1:0]  pressed_q;
  logic [KEY_W-1:0]  event_q;
  logic [KEY_W-1:0]  event_clr;
  logic              take;
  logic              ack_q;
  logic [DATA_W-1:0] rdata_q;

  assign pressed   = ~key_sync;
  assign take      = bus_req_i.stb & ~ack_q;
  assign event_clr = (take && bus_req_i.we && bus_req_i.addr[3:0] == KEY_EVENT_OFS) ?
                     bus_req_i.wdata[KEY_W-1:0] : '0;

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      key_meta  <= '1;  // released
      key_sync  <= '1;
      pressed_q <= '0;
      event_q   <= '0;
      ack_q     <= 1'b0;
    end
    else
    begin
      key_meta  <= key_i;
      key_sync  <= key_meta;
      pressed_q <= pressed;
      // a new press wins over a clear in the same cycle
      event_q   <= (event_q & ~event_clr) | (pressed & ~pressed_q);
      ack_q     <= take;
    end
  end

  always_ff @(posedge clk)
  begin
    if (take)
    begin
      case (bus_req_i.addr[3:0])
        KEY_LEVEL_OFS: rdata_q <= {{(DATA_W-KEY_W){1'b0}}, pressed};
        KEY_EVENT_OFS: rdata_q <= {{(DATA_W-KEY_W){1'b0}}, event_q};
        default:       rdata_q <= '0;
      endcase
    end
  end

  always_comb
  begin
    bus_rsp_o.ack   = ack_q;
    bus_rsp_o.err   = 1'b0;
    bus_rsp_o.rdata = rdata_q;
  end

endmodule

//--- soc_top.sv
module soc_top
  import soc_bus_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n_i,
  input  bus_req_t         bus_req_i,
  output bus_rsp_t         bus_rsp_o,
  input  logic [KEY_W-1:0] key_i,
  output logic [LED_W-1:0] led_o
);

  bus_req_t ram_req;
  bus_rsp_t ram_rsp;
  bus_req_t led_req;
  bus_rsp_t led_rsp;
  bus_req_t key_req;
  bus_rsp_t key_rsp;

  bus_decoder decoder_i (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .bus_req_i (bus_req_i),
    .bus_rsp_o (bus_rsp_o),
    .ram_req_o (ram_req),
    .ram_rsp_i (ram_rsp),
    .led_req_o (led_req),
    .led_rsp_i (led_rsp),
    .key_req_o (key_req),
    .key_rsp_i (key_rsp)
  );

  ram_slave ram_i (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .bus_req_i (ram_req),
    .bus_rsp_o (ram_rsp)
  );

  led_slave led_i (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .bus_req_i (led_req),
    .bus_rsp_o (led_rsp),
    .led_o     (led_o)
  );

  key_slave key_i0 (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .key_i     (key_i),
    .bus_req_i (key_req),
    .bus_rsp_o (key_rsp)
  );

endmodule

//--- tb_soc_top.sv
module tb_soc_top
  import soc_bus_pkg::*;
();

  localparam int NUM_ENTRIES    = 26;
  localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 4 + 50;
  localparam int DRIVE_DLY      = 1;
  localparam int ACK_NEGEDGE    = 2;  // stb sampled at the next edge, ack seen one cycle on
  localparam int KEY_SETTLE     = 3;

  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [SEL_W-1:0]  sel;
    logic [KEY_W-1:0]  key;        // raw pin level, active low
    logic              chk_rdata;
    logic [DATA_W-1:0] exp_rdata;
    logic              exp_err;
    logic [LED_W-1:0]  exp_led;
  } tb_entry_t;

  logic             clk;
  logic             rst_n;
  bus_req_t         bus_req;
  bus_rsp_t         bus_rsp;
  logic [KEY_W-1:0] key_pins;
  logic [LED_W-1:0] led;

  tb_entry_t         table_q [NUM_ENTRIES];
  int                n_built;
  int                cycles;
  integer            seed = 32'h63f9_2a06;
  logic [DATA_W-1:0] ram_model [RAM_WORDS];
  logic [LED_W-1:0]  led_model;
  logic [KEY_W-1:0]  key_model;
  logic [KEY_W-1:0]  event_model;

  soc_top dut_i (
    .clk       (clk),
    .rst_n_i   (rst_n),
    .bus_req_i (bus_req),
    .bus_rsp_o (bus_rsp),
    .key_i     (key_pins),
    .led_o     (led)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "simulation stopped on first failure");
  endtask

  task automatic check_rsp(input bus_rsp_t got, input logic [DATA_W-1:0] exp_rdata,
                           input logic exp_err, input logic chk_rdata);
    if (got.err !== exp_err)
      report_failure($sformatf("error at %0t: err %b expected %b", $time, got.err, exp_err));
    if (chk_rdata && got.rdata !== exp_rdata)
      report_failure($sformatf("error at %0t: rdata %h expected %h", $time, got.rdata,
                               exp_rdata));
  endtask

  task automatic check_led(input logic [LED_W-1:0] got, input logic [LED_W-1:0] exp_led);
    if (got !== exp_led)
      report_failure($sformatf("error at %0t: led_o %h expected %h", $time, got, exp_led));
  endtask

  function automatic logic [DATA_W-1:0] next_word();
    next_word = $random(seed);
  endfunction

  task automatic add_entry(input logic we, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] wdata, input logic [SEL_W-1:0] sel,
                           input logic chk, input logic [DATA_W-1:0] exp_rdata,
                           input logic exp_err);
    tb_entry_t e;
    e.we        = we;
    e.addr      = addr;
    e.wdata     = wdata;
    e.sel       = sel;
    e.key       = key_model;
    e.chk_rdata = chk;
    e.exp_rdata = exp_rdata;
    e.exp_err   = exp_err;
    e.exp_led   = led_model;
    if (n_built < NUM_ENTRIES)
      table_q[n_built] = e;
    n_built++;
  endtask

  task automatic ram_write(input logic [ADDR_W-1:0] ofs, input logic [DATA_W-1:0] data,
                           input logic [SEL_W-1:0] sel);
    logic [RAM_AW-1:0] w;
    w = ofs[RAM_AW+1:2];
    for (int b = 0; b < SEL_W; b++)
    begin
      if (sel[b])
        ram_model[w][8*b +: 8] = data[8*b +: 8];
    end
    add_entry(1'b1, RAM_BASE | ofs, data, sel, 1'b0, '0, 1'b0);
  endtask

  task automatic ram_read(input logic [ADDR_W-1:0] ofs);
    add_entry(1'b0, RAM_BASE | ofs, '0, '1, 1'b1, ram_model[ofs[RAM_AW+1:2]], 1'b0);
  endtask

  task automatic led_write(input logic [DATA_W-1:0] data, input logic [SEL_W-1:0] sel);
    if (sel[0])
      led_model = data[LED_W-1:0];
    add_entry(1'b1, LED_BASE, data, sel, 1'b0, '0, 1'b0);
  endtask

  task automatic led_read();
    add_entry(1'b0, LED_BASE, '0, '1, 1'b1, DATA_W'(led_model), 1'b0);
  endtask

  // a new press latches an event
  task automatic set_keys(input logic [KEY_W-1:0] k);
    event_model = event_model | (~k & key_model);
    key_model   = k;
  endtask

  task automatic key_level_read();
    logic [KEY_W-1:0] level;
    level = ~key_model;  // pressed level, active high
    add_entry(1'b0, KEY_BASE | {28'h0, KEY_LEVEL_OFS}, '0, '1, 1'b1,
              DATA_W'(level), 1'b0);
  endtask

  task automatic key_event_read();
    add_entry(1'b0, KEY_BASE | {28'h0, KEY_EVENT_OFS}, '0, '1, 1'b1,
              DATA_W'(event_model), 1'b0);
  endtask

  task automatic key_event_clear(input logic [KEY_W-1:0] mask);
    event_model = event_model & ~mask;
    add_entry(1'b1, KEY_BASE | {28'h0, KEY_EVENT_OFS}, DATA_W'(mask), '1, 1'b0, '0, 1'b0);
  endtask

  task automatic unmapped_access(input logic we, input logic [ADDR_W-1:0] addr,
                                 input logic [DATA_W-1:0] data);
    add_entry(we, addr, data, '1, 1'b1, '0, 1'b1);
  endtask

  task automatic build_table();
    logic [ADDR_W-1:0] offs [4];
    offs = '{32'h0, 32'h4, 32'h3fc, 32'hffc};  // last one is the top word
    key_event_read();
    for (int i = 0; i < 4; i++)
      ram_write(offs[i], next_word(), 4'hf);
    for (int i = 0; i < 4; i++)
      ram_read(offs[i]);
    ram_write(32'h4, next_word(), 4'b0101);
    ram_read(32'h4);
    ram_write(32'hffc, next_word(), 4'b1000);
    ram_read(32'hffc);
    led_write(next_word(), 4'b0001);
    led_read();
    led_write(next_word(), 4'b1110);  // low lane off, led keeps its value
    led_read();
    set_keys(2'b10);
    key_level_read();
    key_event_read();
    set_keys(2'b11);
    key_level_read();
    key_event_read();
    key_event_clear(2'b01);
    key_event_read();
    unmapped_access(1'b0, 32'h4000_0000, '0);
    unmapped_access(1'b1, 32'h4000_0000, next_word());
    ram_read(32'h0);  // same word index as the unmapped write
  endtask

  // entered and left one drive delay after a rising edge
  task automatic run_access(input tb_entry_t e);
    int waited;
    bus_req.stb   = 1'b1;
    bus_req.we    = e.we;
    bus_req.addr  = e.addr;
    bus_req.wdata = e.wdata;
    bus_req.sel   = e.sel;
    waited = 0;
    do
    begin
      @(negedge clk);
      waited++;
    end
    while (!bus_rsp.ack);
    if (waited != ACK_NEGEDGE)
      report_failure($sformatf("error at %0t: ack after %0d falling edges, expected %0d",
                               $time, waited, ACK_NEGEDGE));
    check_rsp(bus_rsp, e.exp_rdata, e.exp_err, e.chk_rdata);
    @(posedge clk);
    #DRIVE_DLY;
    bus_req = '0;
    @(negedge clk);
    if (bus_rsp.ack)
      report_failure($sformatf("error at %0t: ack high for more than one cycle", $time));
    check_led(led, e.exp_led);
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  initial
  begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycles++;
    end
    report_failure($sformatf("timeout: test did not finish within %0d cycles",
                             TIMEOUT_CYCLES));
  end

  initial
  begin
    rst_n       = 1'b0;
    bus_req     = '0;
    key_pins    = '1;  // released
    n_built     = 0;
    led_model   = '0;
    key_model   = '1;
    event_model = '0;
    build_table();
    if (n_built != NUM_ENTRIES)
      report_failure($sformatf("stimulus table holds %0d entries instead of %0d",
                               n_built, NUM_ENTRIES));
    repeat (2) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    check_led(led, '0);
    for (int i = 0; i < NUM_ENTRIES; i++)
    begin
      if (table_q[i].key !== key_pins)
      begin
        key_pins = table_q[i].key;
        repeat (KEY_SETTLE) @(posedge clk);  // through the synchronizer
        #DRIVE_DLY;
      end
      run_access(table_q[i]);
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

//--- soc_top.f
soc_bus_pkg.sv
bus_decoder.sv
ram_slave.sv
led_slave.sv
key_slave.sv
soc_top.sv
tb_soc_top.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_soc_top -f soc_top.f -o tb_sim \
  > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TB PASSED" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
